// File: rv32i_types.sv
package rv32i_types;

	// basic data and address word
	typedef logic [31:0] rv32i_word;
	// register file index
	typedef logic [4:0] rv32i_reg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_br    = 7'b1100011,
		op_jal   = 7'b1101111
	} rv32i_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_ops;

	// writeback source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc_plus4
	} wb_sel_t;

	// decoded instruction, carried down the pipe
	typedef struct packed {
		rv32i_opcode opcode;
		alu_ops      alu_op;
		logic        alu_src_imm;
		wb_sel_t     wb_sel;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		logic        branch;
		logic        branch_ne;
		logic        jump;
		rv32i_reg    rs1;
		rv32i_reg    rs2;
		rv32i_reg    rd;
		rv32i_word   imm;
	} rv32i_control_word;

	// addi x0, x0, 0 equivalent, nothing gets written
	localparam rv32i_control_word nop_ctrl = '{
		opcode:      op_imm,
		alu_op:      alu_add,
		alu_src_imm: 1'b0,
		wb_sel:      wb_alu,
		reg_write:   1'b0,
		mem_read:    1'b0,
		mem_write:   1'b0,
		branch:      1'b0,
		branch_ne:   1'b0,
		jump:        1'b0,
		rs1:         5'd0,
		rs2:         5'd0,
		rd:          5'd0,
		imm:         32'd0
	};

	localparam rv32i_word reset_pc = 32'h0000_0000;
	// sequential instruction step
	localparam rv32i_word pc_step = 32'd4;
	// full-word accesses only
	localparam logic [3:0] mbe_word = 4'b1111;

endpackage

// File: pipe_types.sv
package pipe_types;

	import rv32i_types::*;

	// fetch to decode
	typedef struct packed {
		logic      valid;
		rv32i_word pc;
		rv32i_word inst;
	} if_id_t;

	// decode to execute, register values as read in decode
	typedef struct packed {
		logic              valid;
		rv32i_word         pc;
		rv32i_control_word ctrl;
		rv32i_word         rs1_data;
		rv32i_word         rs2_data;
	} id_ex_t;

	// execute to memory, branch outcome resolved here
	typedef struct packed {
		logic              valid;
		rv32i_word         pc;
		rv32i_control_word ctrl;
		rv32i_word         alu_out;
		rv32i_word         rs2_data;
		logic              br_take;
		rv32i_word         target;
	} ex_mem_t;

	// memory to writeback
	typedef struct packed {
		logic              valid;
		rv32i_word         pc;
		rv32i_control_word ctrl;
		rv32i_word         alu_out;
		rv32i_word         mem_rdata;
	} mem_wb_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_none,
		fwd_from_mem,
		fwd_from_wb
	} fwd_sel_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import rv32i_types::*;
	import pipe_types::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      stall,
	input  logic      redirect,
	input  rv32i_word redirect_pc,
	input  logic      inst_resp,
	input  rv32i_word inst_rdata,
	output logic      inst_read,
	output rv32i_word inst_addr,
	output if_id_t    if_out
);

	// pc is the address of the instruction being fetched or buffered
	rv32i_word pc;
	logic      running;
	// response that came in while the pipe was held
	logic      buf_valid;
	rv32i_word buf_inst;
	logic      resp_ok;
	logic      have_inst;
	rv32i_word next_inst;

	// no new request while an instruction waits in the buffer
	assign inst_read = running && !buf_valid;
	assign inst_addr = pc;
	assign resp_ok   = inst_read && inst_resp;
	assign have_inst = resp_ok || buf_valid;
	assign next_inst = buf_valid ? buf_inst : inst_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running      <= 1'b0;
			buf_valid    <= 1'b0;
			pc           <= reset_pc;
			if_out.valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (redirect) begin
				// wrong-path response of this cycle is dropped
				pc           <= redirect_pc;
				buf_valid    <= 1'b0;
				if_out.valid <= 1'b0;
			end else if (!stall) begin
				if_out.valid <= have_inst;
				if (have_inst) begin
					pc          <= pc + pc_step;
					buf_valid   <= 1'b0;
					if_out.pc   <= pc;
					if_out.inst <= next_inst;
				end
			end else if (resp_ok) begin
				// pipe frozen, park the word until it can move
				buf_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp_ok) begin
			buf_inst <= inst_rdata;
		end
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import rv32i_types::*;
	import pipe_types::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  if_id_t    if_in,
	input  logic      wb_write,
	input  rv32i_reg  wb_rd,
	input  rv32i_word wb_data,
	output id_ex_t    id_out
);

	rv32i_word         regs [32];
	rv32i_word         inst;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	rv32i_word         imm_i;
	rv32i_word         imm_s;
	rv32i_word         imm_b;
	rv32i_word         imm_u;
	rv32i_word         imm_j;
	alu_ops            arith_op;
	logic              arith_ok;
	rv32i_control_word base;
	rv32i_control_word ctrl;
	rv32i_word         rs1_data;
	rv32i_word         rs2_data;

	assign inst   = if_in.inst;
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// immediates, all sign extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct3 to alu op, shared by op_imm and op_reg
	always_comb begin
		arith_ok = 1'b1;
		case (funct3)
			3'b000: arith_op = alu_add;
			3'b010: arith_op = alu_slt;
			3'b100: arith_op = alu_xor;
			3'b110: arith_op = alu_or;
			3'b111: arith_op = alu_and;
			default: begin
				arith_op = alu_add;
				arith_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		base     = nop_ctrl;
		base.rs1 = inst[19:15];
		base.rs2 = inst[24:20];
		base.rd  = inst[11:7];
		// anything not matched stays a nop
		ctrl = nop_ctrl;
		case (inst[6:0])
			op_lui: begin
				ctrl             = base;
				ctrl.opcode      = op_lui;
				ctrl.alu_op      = alu_pass_b;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.imm         = imm_u;
			end
			op_imm: begin
				if (arith_ok) begin
					ctrl             = base;
					ctrl.alu_op      = arith_op;
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_write   = 1'b1;
					ctrl.imm         = imm_i;
				end
			end
			op_reg: begin
				// only sub may carry funct7 bit 5
				if (arith_ok && (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && funct3 == 3'b000))) begin
					ctrl           = base;
					ctrl.opcode    = op_reg;
					ctrl.alu_op    = funct7[5] ? alu_sub : arith_op;
					ctrl.reg_write = 1'b1;
				end
			end
			op_load: begin
				if (funct3 == 3'b010) begin
					ctrl             = base;
					ctrl.opcode      = op_load;
					ctrl.alu_src_imm = 1'b1;
					ctrl.wb_sel      = wb_mem;
					ctrl.reg_write   = 1'b1;
					ctrl.mem_read    = 1'b1;
					ctrl.imm         = imm_i;
				end
			end
			op_store: begin
				if (funct3 == 3'b010) begin
					ctrl             = base;
					ctrl.opcode      = op_store;
					ctrl.alu_src_imm = 1'b1;
					ctrl.mem_write   = 1'b1;
					ctrl.imm         = imm_s;
				end
			end
			op_br: begin
				// beq and bne only
				if (funct3[2:1] == 2'b00) begin
					ctrl           = base;
					ctrl.opcode    = op_br;
					ctrl.branch    = 1'b1;
					ctrl.branch_ne = funct3[0];
					ctrl.imm       = imm_b;
				end
			end
			op_jal: begin
				ctrl           = base;
				ctrl.opcode    = op_jal;
				ctrl.wb_sel    = wb_pc_plus4;
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
				ctrl.imm       = imm_j;
			end
			default: ctrl = nop_ctrl;
		endcase
	end

	// x0 stays zero, writes to it are ignored
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// write-through so decode sees this cycle's writeback
	assign rs1_data = (ctrl.rs1 == '0) ? '0 :
		(wb_write && wb_rd == ctrl.rs1) ? wb_data : regs[ctrl.rs1];
	assign rs2_data = (ctrl.rs2 == '0) ? '0 :
		(wb_write && wb_rd == ctrl.rs2) ? wb_data : regs[ctrl.rs2];

	always_comb begin
		id_out.valid    = if_in.valid;
		id_out.pc       = if_in.pc;
		id_out.ctrl     = ctrl;
		id_out.rs1_data = rs1_data;
		id_out.rs2_data = rs2_data;
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import rv32i_types::*;
	import pipe_types::*;
(
	input  id_ex_t    ex_in,
	input  fwd_sel_t  fwd_a,
	input  fwd_sel_t  fwd_b,
	input  rv32i_word mem_fwd_data,
	input  rv32i_word wb_fwd_data,
	output ex_mem_t   ex_out
);

	rv32i_word op_a;
	rv32i_word op_b_reg;
	rv32i_word op_b;
	rv32i_word alu_out;
	logic      equal;
	logic      cond;

	// pick the youngest copy of a source register
	function automatic rv32i_word pick(fwd_sel_t sel, rv32i_word own,
			rv32i_word from_mem, rv32i_word from_wb);
		case (sel)
			fwd_from_mem: return from_mem;
			fwd_from_wb:  return from_wb;
			default:      return own;
		endcase
	endfunction

	assign op_a     = pick(fwd_a, ex_in.rs1_data, mem_fwd_data, wb_fwd_data);
	assign op_b_reg = pick(fwd_b, ex_in.rs2_data, mem_fwd_data, wb_fwd_data);
	// second operand is the immediate for lui, op_imm, loads and stores
	assign op_b     = ex_in.ctrl.alu_src_imm ? ex_in.ctrl.imm : op_b_reg;

	always_comb begin
		case (ex_in.ctrl.alu_op)
			alu_add:    alu_out = op_a + op_b;
			alu_sub:    alu_out = op_a - op_b;
			alu_and:    alu_out = op_a & op_b;
			alu_or:     alu_out = op_a | op_b;
			alu_xor:    alu_out = op_a ^ op_b;
			alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			alu_pass_b: alu_out = op_b;
			default:    alu_out = op_a + op_b;
		endcase
	end

	// branch compare always on register operands
	assign equal = (op_a == op_b_reg);
	assign cond  = ex_in.ctrl.branch_ne ? !equal : equal;

	always_comb begin
		ex_out.valid    = ex_in.valid;
		ex_out.pc       = ex_in.pc;
		ex_out.ctrl     = ex_in.ctrl;
		ex_out.alu_out  = alu_out;
		// store data after forwarding
		ex_out.rs2_data = op_b_reg;
		ex_out.br_take  = ex_in.valid && ((ex_in.ctrl.branch && cond) || ex_in.ctrl.jump);
		ex_out.target   = ex_in.pc + ex_in.ctrl.imm;
	end

endmodule

// File: hazard_detection.sv
`timescale 1ns/1ps

module hazard_detection
	import rv32i_types::*;
	import pipe_types::*;
(
	input  id_ex_t   id_ex,
	input  ex_mem_t  ex_mem,
	input  mem_wb_t  mem_wb,
	input  rv32i_reg if_inst_rs1,
	input  rv32i_reg if_inst_rs2,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output logic     load_use
);

	logic mem_writes;
	logic wb_writes;

	// stages that will write a real register
	assign mem_writes = ex_mem.valid && ex_mem.ctrl.reg_write && (ex_mem.ctrl.rd != '0);
	assign wb_writes  = mem_wb.valid && mem_wb.ctrl.reg_write && (mem_wb.ctrl.rd != '0);

	// memory stage wins, it holds the younger result
	function automatic fwd_sel_t select(rv32i_reg src, logic mem_en, rv32i_reg mem_rd,
			logic wb_en, rv32i_reg wb_rd);
		if (mem_en && mem_rd == src) return fwd_from_mem;
		if (wb_en && wb_rd == src) return fwd_from_wb;
		return fwd_none;
	endfunction

	assign fwd_a = select(id_ex.ctrl.rs1, mem_writes, ex_mem.ctrl.rd, wb_writes, mem_wb.ctrl.rd);
	assign fwd_b = select(id_ex.ctrl.rs2, mem_writes, ex_mem.ctrl.rd, wb_writes, mem_wb.ctrl.rd);

	// load in execute, consumer right behind it in decode
	assign load_use = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.ctrl.rd != '0) &&
		(id_ex.ctrl.rd == if_inst_rs1 || id_ex.ctrl.rd == if_inst_rs2);

endmodule

// File: cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
	import rv32i_types::*;
	import pipe_types::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// instruction port
	input  logic       inst_resp,
	input  rv32i_word  inst_rdata,
	output logic       inst_read,
	output rv32i_word  inst_addr,
	// data port
	input  logic       data_resp,
	input  rv32i_word  data_rdata,
	output logic       data_read,
	output logic       data_write,
	output logic [3:0] data_mbe,
	output rv32i_word  data_addr,
	output rv32i_word  data_wdata
);

	if_id_t    if_id;
	id_ex_t    id_next;
	id_ex_t    id_ex;
	ex_mem_t   ex_next;
	ex_mem_t   ex_mem;
	mem_wb_t   mem_wb;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	logic      load_use;
	logic      stall;
	logic      flush;
	logic      fetch_hold;
	// memory access of ex_mem already answered and waiting for the pipe
	logic      data_done;
	rv32i_word rdata_hold;
	logic      mem_access;
	rv32i_word mem_rdata_now;
	rv32i_word mem_fwd_data;
	rv32i_word wb_data;
	logic      wb_write;

	// outstanding requests freeze the whole pipe
	assign mem_access = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) &&
		!data_done;
	assign stall      = (inst_read && !inst_resp) || (mem_access && !data_resp);
	// branch and jal resolve in the memory stage
	assign flush      = ex_mem.valid && ex_mem.br_take && !stall;
	// load-use bubble also holds pc and if_id
	assign fetch_hold = stall || load_use;

	fetch_stage u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (fetch_hold),
		.redirect    (flush),
		.redirect_pc (ex_mem.target),
		.inst_resp   (inst_resp),
		.inst_rdata  (inst_rdata),
		.inst_read   (inst_read),
		.inst_addr   (inst_addr),
		.if_out      (if_id)
	);

	decode_stage u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_in    (if_id),
		.wb_write (wb_write),
		.wb_rd    (mem_wb.ctrl.rd),
		.wb_data  (wb_data),
		.id_out   (id_next)
	);

	execute_stage u_execute (
		.ex_in        (id_ex),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.mem_fwd_data (mem_fwd_data),
		.wb_fwd_data  (wb_data),
		.ex_out       (ex_next)
	);

	hazard_detection u_hazard (
		.id_ex       (id_ex),
		.ex_mem      (ex_mem),
		.mem_wb      (mem_wb),
		.if_inst_rs1 (if_id.inst[19:15]),
		.if_inst_rs2 (if_id.inst[24:20]),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.load_use    (load_use)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
		end else if (!stall) begin
			id_ex       <= id_next;
			// flushed or bubbled entry
			id_ex.valid <= id_next.valid && !flush && !load_use;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
		end else if (!stall) begin
			ex_mem       <= ex_next;
			ex_mem.valid <= ex_next.valid && !flush;
		end
	end

	// data port driven straight from ex_mem
	assign data_read  = mem_access && ex_mem.ctrl.mem_read;
	assign data_write = mem_access && ex_mem.ctrl.mem_write;
	assign data_mbe   = mbe_word;
	assign data_addr  = ex_mem.alu_out;
	assign data_wdata = ex_mem.rs2_data;

	// answer arrived while the fetch side still holds the pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_done <= 1'b0;
		end else if (!stall) begin
			data_done <= 1'b0;
		end else if (mem_access && data_resp) begin
			data_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_access && data_resp) begin
			rdata_hold <= data_rdata;
		end
	end

	assign mem_rdata_now = data_done ? rdata_hold : data_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.valid <= 1'b0;
		end else if (!stall) begin
			mem_wb.valid     <= ex_mem.valid;
			mem_wb.pc        <= ex_mem.pc;
			mem_wb.ctrl      <= ex_mem.ctrl;
			mem_wb.alu_out   <= ex_mem.alu_out;
			mem_wb.mem_rdata <= mem_rdata_now;
		end
	end

	// alu result of the memory-stage instruction
	// loads and jal never feed execute from here
	// their consumers are bubbled or flushed
	assign mem_fwd_data = ex_mem.alu_out;

	always_comb begin
		case (mem_wb.ctrl.wb_sel)
			wb_mem:      wb_data = mem_wb.mem_rdata;
			wb_pc_plus4: wb_data = mem_wb.pc + pc_step;
			default:     wb_data = mem_wb.alu_out;
		endcase
	end

	assign wb_write = mem_wb.valid && mem_wb.ctrl.reg_write;

endmodule

// File: tb_cpu_datapath.sv
`timescale 1ns/1ps

module tb_cpu_datapath
	import rv32i_types::*;
();

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	logic       inst_resp = 1'b0;
	rv32i_word  inst_rdata = '0;
	logic       inst_read;
	rv32i_word  inst_addr;
	logic       data_resp = 1'b0;
	rv32i_word  data_rdata = '0;
	logic       data_read;
	logic       data_write;
	logic [3:0] data_mbe;
	rv32i_word  data_addr;
	rv32i_word  data_wdata;

	// shared instruction and data memory, 4 KiB
	rv32i_word  mem [1024];
	int         lat_table [256];
	logic [7:0] lat_idx = '0;
	logic       slow_mem = 1'b0;
	int         seed = 2693;
	int         rnd_imm [8];
	rv32i_word  load_pc;
	// stores the reference expects, in order
	rv32i_word  exp_addr [$];
	rv32i_word  exp_data [$];
	int         store_idx = 0;
	logic       end_seen = 1'b0;
	int         check_errors = 0;
	int         other_errors = 0;
	logic       i_busy;
	logic       d_busy;
	int         i_wait;
	int         d_wait;

	initial begin
		forever #4 clk = ~clk;
	end

	cpu_datapath UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_resp  (inst_resp),
		.inst_rdata (inst_rdata),
		.inst_read  (inst_read),
		.inst_addr  (inst_addr),
		.data_resp  (data_resp),
		.data_rdata (data_rdata),
		.data_read  (data_read),
		.data_write (data_write),
		.data_mbe   (data_mbe),
		.data_addr  (data_addr),
		.data_wdata (data_wdata)
	);

	// memory model, one resp per request after a table-driven delay
	always @(posedge clk) begin
		if (!rst_n) begin
			inst_resp <= 1'b0;
			data_resp <= 1'b0;
			i_busy = 1'b0;
			d_busy = 1'b0;
		end else begin
			if (inst_resp) begin
				inst_resp <= 1'b0;
				i_busy = 1'b0;
			end else if (inst_read === 1'b1) begin
				if (!i_busy) begin
					i_busy  = 1'b1;
					i_wait  = slow_mem ? 3 : lat_table[lat_idx];
					lat_idx = lat_idx + 8'd1;
				end
				if (i_wait == 0) begin
					inst_resp  <= 1'b1;
					inst_rdata <= mem[inst_addr[11:2]];
				end else begin
					i_wait = i_wait - 1;
				end
			end
			// data port, store lands in the answered cycle
			if (data_resp) begin
				data_resp <= 1'b0;
				d_busy = 1'b0;
				if (data_write) begin
					mem[data_addr[11:2]] = data_wdata;
				end
			end else if (data_read === 1'b1 || data_write === 1'b1) begin
				if (!d_busy) begin
					d_busy  = 1'b1;
					d_wait  = slow_mem ? 3 : lat_table[lat_idx];
					lat_idx = lat_idx + 8'd1;
				end
				if (d_wait == 0) begin
					data_resp  <= 1'b1;
					data_rdata <= mem[data_addr[11:2]];
				end else begin
					d_wait = d_wait - 1;
				end
			end
		end
	end

	// store checker, compares each answered store in order
	always @(posedge clk) begin
		if (!rst_n) begin
			store_idx <= 0;
			end_seen  <= 1'b0;
		end else if (data_write && data_resp) begin
			if (store_idx >= exp_addr.size()) begin
				check_errors++;
				$display("unexpected store to %h with data %h", data_addr, data_wdata);
			end else begin
				if (data_addr !== exp_addr[store_idx]) begin
					check_errors++;
					$display("MISMATCH data_addr: got %h, expected %h",
						data_addr, exp_addr[store_idx]);
				end
				if (data_wdata !== exp_data[store_idx]) begin
					check_errors++;
					$display("MISMATCH data_wdata: got %h, expected %h",
						data_wdata, exp_data[store_idx]);
				end
			end
			if (data_mbe !== 4'hF) begin
				check_errors++;
				$display("MISMATCH data_mbe: got %h, expected %h", data_mbe, 4'hF);
			end
			store_idx <= store_idx + 1;
			if (data_addr == 32'h0000_0FFC) begin
				end_seen <= 1'b1;
			end
		end
	end

	// instruction encoders
	function automatic rv32i_word addi_word(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic rv32i_word rr_word(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rv32i_word lui_word(int rd, int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic rv32i_word lw_word(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic rv32i_word sw_word(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// f3 0 is beq, 1 is bne
	function automatic rv32i_word br_word(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic rv32i_word jal_word(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic emit(rv32i_word w);
		mem[load_pc[11:2]] = w;
		load_pc = load_pc + 32'd4;
	endtask

	// wrong-path stores, never expected
	task automatic add_poison_stores();
		emit(sw_word(3, 30, 128));
		emit(sw_word(3, 30, 132));
		emit(sw_word(3, 30, 136));
	endtask

	task automatic load_program(int which);
		// fill derived from the whole word address
		for (int i = 0; i < 1024; i++) begin
			mem[i] = (i * 32'h0101_0004) ^ 32'hA5A5_5A5A;
		end
		load_pc = '0;
		emit(addi_word(30, 0, 1024));
		case (which)
			0: begin
				// dependent alu chain
				emit(addi_word(1, 0, rnd_imm[0]));
				emit(addi_word(2, 1, rnd_imm[1]));
				emit(rr_word(0, 0, 3, 2, 1));
				emit(rr_word(32, 0, 4, 3, 2));
				emit(rr_word(0, 7, 5, 4, 3));
				emit(rr_word(0, 6, 6, 5, 1));
				emit(rr_word(0, 4, 7, 6, 4));
				emit(rr_word(0, 2, 8, 7, 6));
				emit(lui_word(9, rnd_imm[2]));
				emit(rr_word(0, 0, 10, 9, 7));
				// store data straight from the memory stage
				emit(sw_word(10, 30, 64));
				emit(addi_word(11, 8, rnd_imm[3]));
				emit(rr_word(0, 2, 12, 6, 7));
				for (int r = 1; r <= 12; r++) begin
					emit(sw_word(r, 30, 4 * (r - 1)));
				end
			end
			1: begin
				// loads used right away, as rs2, rs1 and store data
				emit(addi_word(1, 0, rnd_imm[4]));
				emit(sw_word(1, 30, 0));
				emit(addi_word(2, 0, rnd_imm[5]));
				emit(lw_word(3, 30, 0));
				emit(rr_word(0, 0, 4, 2, 3));
				emit(sw_word(4, 30, 4));
				emit(lw_word(5, 30, 4));
				emit(rr_word(32, 0, 6, 5, 1));
				emit(sw_word(6, 30, 8));
				emit(lw_word(7, 30, 8));
				emit(sw_word(7, 30, 12));
				// word from the fill pattern
				emit(lw_word(8, 30, 64));
				emit(rr_word(0, 4, 9, 8, 4));
				emit(sw_word(9, 30, 16));
			end
			default: begin
				emit(addi_word(1, 0, 5));
				emit(addi_word(3, 0, 7));
				emit(addi_word(2, 0, 5));
				// taken beq
				emit(br_word(0, 1, 2, 16));
				add_poison_stores();
				emit(sw_word(1, 30, 0));
				// not taken bne, then not taken beq
				emit(br_word(1, 1, 2, 16));
				emit(sw_word(2, 30, 4));
				emit(br_word(0, 1, 3, 16));
				emit(sw_word(3, 30, 8));
				// taken bne
				emit(br_word(1, 1, 3, 16));
				add_poison_stores();
				emit(sw_word(3, 30, 12));
				emit(jal_word(5, 16));
				add_poison_stores();
				// link register
				emit(sw_word(5, 30, 16));
				emit(addi_word(6, 5, 1));
				emit(sw_word(6, 30, 20));
			end
		endcase
		// end marker at 0xffc, then spin
		emit(lui_word(31, 1));
		emit(sw_word(1, 31, -4));
		emit(jal_word(0, 0));
	endtask

	// {funct7 bit 5, funct3}
	function automatic rv32i_word alu_ref(logic [3:0] sel, rv32i_word a, rv32i_word b);
		case (sel)
			4'b0000: return a + b;
			4'b1000: return a - b;
			4'b0010: return {31'b0, $signed(a) < $signed(b)};
			4'b0100: return a ^ b;
			4'b0110: return a | b;
			4'b0111: return a & b;
			default: return '0;
		endcase
	endfunction

	// instruction-set model of the loaded program
	function automatic void exec_program();
		rv32i_word rf [32];
		rv32i_word dm [1024];
		rv32i_word pc;
		rv32i_word npc;
		rv32i_word w;
		rv32i_word a;
		rv32i_word b;
		rv32i_word imm_i;
		rv32i_word imm_s;
		rv32i_word res;
		rv32i_word addr;
		logic      wr;
		exp_addr.delete();
		exp_data.delete();
		dm = mem;
		for (int r = 0; r < 32; r++) begin
			rf[r] = '0;
		end
		pc = '0;
		for (int step = 0; step < 4000; step++) begin
			w     = dm[pc[11:2]];
			a     = rf[w[19:15]];
			b     = rf[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			res   = '0;
			wr    = 1'b1;
			npc   = pc + 32'd4;
			case (w[6:0])
				7'b0110111: res = {w[31:12], 12'b0};
				7'b0010011: res = alu_ref({1'b0, w[14:12]}, a, imm_i);
				7'b0110011: res = alu_ref({w[30], w[14:12]}, a, b);
				7'b0000011: begin
					addr = a + imm_i;
					res  = dm[addr[11:2]];
				end
				7'b0100011: begin
					wr   = 1'b0;
					addr = a + imm_s;
					dm[addr[11:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					if (addr == 32'h0000_0FFC) begin
						return;
					end
				end
				7'b1100011: begin
					wr = 1'b0;
					if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
						npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					end
				end
				7'b1101111: begin
					res = pc + 32'd4;
					npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				default: wr = 1'b0;
			endcase
			if (wr && w[11:7] != 5'd0) begin
				rf[w[11:7]] = res;
			end
			pc = npc;
		end
	endfunction

	// first request after reset must fetch address 0
	task automatic check_first_fetch();
		int n;
		n = 0;
		@(posedge clk);
		while (inst_read !== 1'b1 && n < 20) begin
			if (data_read !== 1'b0 || data_write !== 1'b0) begin
				other_errors++;
				$display("data port active right after reset");
			end
			@(posedge clk);
			n++;
		end
		if (n >= 20) begin
			other_errors++;
			$display("no instruction fetch after reset");
		end else if (inst_addr !== 32'h0) begin
			other_errors++;
			$display("MISMATCH inst_addr: got %h, expected %h", inst_addr, 32'h0);
		end
	endtask

	task automatic run_program(int which, logic slow);
		int n;
		@(posedge clk);
		rst_n    <= 1'b0;
		slow_mem <= slow;
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			// core is quiet from here, safe to reload memory
			if (i == 0) begin
				load_program(which);
				exec_program();
			end else if (data_read !== 1'b0 || data_write !== 1'b0) begin
				other_errors++;
				$display("data port active during reset, program %0d", which);
			end
		end
		rst_n <= 1'b1;
		check_first_fetch();
		n = 0;
		while (end_seen !== 1'b1 && n < 5000) begin
			@(posedge clk);
			n++;
		end
		if (end_seen !== 1'b1) begin
			other_errors++;
			$display("program %0d did not reach its end marker", which);
		end else if (store_idx != exp_addr.size()) begin
			other_errors++;
			$display("program %0d made %0d stores, reference has %0d",
				which, store_idx, exp_addr.size());
		end
	endtask

	initial begin
		for (int i = 0; i < 8; i++) begin
			rnd_imm[i] = $random(seed);
		end
		for (int i = 0; i < 256; i++) begin
			lat_table[i] = $unsigned($random(seed)) % 4;
		end
		// random latency first, then every response at the slowest
		for (int slow = 0; slow < 2; slow++) begin
			for (int p = 0; p < 3; p++) begin
				run_program(p, slow[0]);
			end
		end
		$display("store check errors: %0d, other errors: %0d", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: compile.f
rv32i_types.sv
pipe_types.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
hazard_detection.sv
cpu_datapath.sv
tb_cpu_datapath.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_datapath testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module tb_cpu_datapath
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cpu_datapath > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Something failed" sim.log; then
	echo "testbench reported errors, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0
